// ==== common/exu_pkg.sv ====
// Shared widths, reset and trap vectors, jump mask
// Opcode and select enums, decoded command and register write port structs

`default_nettype none

package exu_pkg;

    //--------------------------------------------------------------------------
    // Widths and constants
    //--------------------------------------------------------------------------
    localparam int unsigned xlen          = 32;
    localparam int unsigned rf_addr_width = 5;
    localparam int unsigned rf_depth      = 32;

    localparam logic [xlen-1:0] rst_vector  = 32'h0000_0200;  // PC after reset
    localparam logic [xlen-1:0] trap_vector = 32'h0000_0100;  // Exception entry
    localparam logic [xlen-1:0] jump_mask   = 32'hffff_fffe;  // Clears target bit 0

    //--------------------------------------------------------------------------
    // Opcodes and selects
    //--------------------------------------------------------------------------
    typedef enum logic {
        ialu_op_reg_reg,                                       // op2 = rs2
        ialu_op_reg_imm                                        // op2 = imm
    } ialu_op_e;

    typedef enum logic {
        sum2_op_reg_imm,                                       // rs1 + imm
        sum2_op_pc_imm                                         // pc + imm
    } sum2_op_e;

    typedef enum logic [4:0] {
        ialu_cmd_none,
        ialu_cmd_add,
        ialu_cmd_sub,
        ialu_cmd_and,
        ialu_cmd_or,
        ialu_cmd_xor,
        ialu_cmd_sll,
        ialu_cmd_srl,
        ialu_cmd_sra,
        ialu_cmd_slt,
        ialu_cmd_sltu,
        ialu_cmd_eq,                                           // Branch compares
        ialu_cmd_ne,
        ialu_cmd_lt,
        ialu_cmd_ge,
        ialu_cmd_ltu,
        ialu_cmd_geu
    } ialu_cmd_e;

    typedef enum logic [2:0] {
        rd_wb_none,
        rd_wb_ialu,
        rd_wb_sum2,
        rd_wb_imm,
        rd_wb_inc_pc
    } rd_wb_sel_e;

    // RISC-V mcause values
    typedef enum logic [3:0] {
        exc_code_instr_misalign = 4'd0,
        exc_code_illegal_instr  = 4'd2
    } exc_code_e;

    //--------------------------------------------------------------------------
    // Structs
    //--------------------------------------------------------------------------
    typedef struct packed {
        ialu_op_e                 ialu_op;
        ialu_cmd_e                ialu_cmd;
        sum2_op_e                 sum2_op;
        rd_wb_sel_e               rd_wb_sel;
        logic                     jump_req;
        logic                     branch_req;
        logic                     exc_req;                     // Set by the decoder
        exc_code_e                exc_code;
        logic [rf_addr_width-1:0] rs1_addr;
        logic [rf_addr_width-1:0] rs2_addr;
        logic [rf_addr_width-1:0] rd_addr;
        logic [xlen-1:0]          imm;
    } exu_cmd_t;

    typedef struct packed {
        logic                     w_req;
        logic [rf_addr_width-1:0] rd_addr;
        logic [xlen-1:0]          rd_data;
    } rf_wr_t;

endpackage

`default_nettype wire

// ==== exu/exu_queue.sv ====
// Single-entry command queue
// Valid flag dropped for a command that arrives during a redirect

`default_nettype none

module exu_queue (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              cmd_req,
    input  wire exu_pkg::exu_cmd_t cmd,
    input  wire logic              new_pc_req,   // Redirect from the executing command
    output logic                   q_vd,
    output exu_pkg::exu_cmd_t      q_cmd
);

    //--------------------------------------------------------------------------
    // Valid flag
    //--------------------------------------------------------------------------
    // The EXU finishes every command in one cycle, so the flag is
    // reloaded on each edge and never has to hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_vd <= 1'b0;
        end else begin
            q_vd <= cmd_req & ~new_pc_req;          // Wrong-path command is lost
        end
    end

    //--------------------------------------------------------------------------
    // Command payload
    //--------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (cmd_req) begin
            q_cmd <= cmd;                           // Ignored while q_vd is low
        end
    end

endmodule

`default_nettype wire

// ==== exu/exu_execute.sv ====
// Operand select, integer ALU and branch compare
// Address adder for jump targets and AUIPC, register write-back select

`default_nettype none

module exu_execute (
    input  wire logic                        q_vd,
    input  wire exu_pkg::exu_cmd_t           q_cmd,
    input  wire logic [exu_pkg::xlen-1:0]    rs1_data,
    input  wire logic [exu_pkg::xlen-1:0]    rs2_data,
    input  wire logic [exu_pkg::xlen-1:0]    curr_pc,
    input  wire logic [exu_pkg::xlen-1:0]    inc_pc,
    input  wire logic                        exc_req,   // Trap on this command
    output logic [exu_pkg::xlen-1:0]         sum2_res,
    output logic                             cmp,
    output exu_pkg::rf_wr_t                  wb
);
    import exu_pkg::*;

    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] sum2_base;
    logic [xlen:0]   diff;                          // Extra bit holds the borrow
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [xlen-1:0] ialu_res;

    //--------------------------------------------------------------------------
    // Operand fetch
    //--------------------------------------------------------------------------
    assign op1       = rs1_data;
    assign op2       = (q_cmd.ialu_op == ialu_op_reg_reg) ? rs2_data : q_cmd.imm;
    assign sum2_base = (q_cmd.sum2_op == sum2_op_reg_imm) ? rs1_data : curr_pc;
    assign sum2_res  = sum2_base + q_cmd.imm;       // Jump / branch target

    //--------------------------------------------------------------------------
    // Compare
    //--------------------------------------------------------------------------
    assign diff = {1'b0, op1} - {1'b0, op2};
    assign eq   = (op1 == op2);
    assign lt_u = diff[xlen];                       // Borrow out
    assign lt_s = (op1[xlen-1] != op2[xlen-1]) ? op1[xlen-1] : diff[xlen-1];

    always_comb begin
        case (q_cmd.ialu_cmd)
            ialu_cmd_eq:                cmp = eq;
            ialu_cmd_ne:                cmp = ~eq;
            ialu_cmd_lt, ialu_cmd_slt:  cmp = lt_s;
            ialu_cmd_ge:                cmp = ~lt_s;
            ialu_cmd_ltu, ialu_cmd_sltu: cmp = lt_u;
            ialu_cmd_geu:               cmp = ~lt_u;
            default:                    cmp = 1'b0;
        endcase
    end

    //--------------------------------------------------------------------------
    // Integer ALU
    //--------------------------------------------------------------------------
    always_comb begin
        case (q_cmd.ialu_cmd)
            ialu_cmd_add:  ialu_res = op1 + op2;
            ialu_cmd_sub:  ialu_res = diff[xlen-1:0];
            ialu_cmd_and:  ialu_res = op1 & op2;
            ialu_cmd_or:   ialu_res = op1 | op2;
            ialu_cmd_xor:  ialu_res = op1 ^ op2;
            ialu_cmd_sll:  ialu_res = op1 << op2[4:0];
            ialu_cmd_srl:  ialu_res = op1 >> op2[4:0];
            ialu_cmd_sra:  ialu_res = $unsigned($signed(op1) >>> op2[4:0]);
            ialu_cmd_slt,
            ialu_cmd_sltu: ialu_res = {{(xlen-1){1'b0}}, cmp};
            default:       ialu_res = '0;
        endcase
    end

    //--------------------------------------------------------------------------
    // Write back
    //--------------------------------------------------------------------------
    always_comb begin
        wb.w_req   = q_vd & (q_cmd.rd_wb_sel != rd_wb_none) & ~exc_req;
        wb.rd_addr = q_cmd.rd_addr;
        case (q_cmd.rd_wb_sel)
            rd_wb_sum2:   wb.rd_data = sum2_res;    // AUIPC
            rd_wb_imm:    wb.rd_data = q_cmd.imm;   // LUI
            rd_wb_inc_pc: wb.rd_data = inc_pc;      // Link address
            default:      wb.rd_data = ialu_res;
        endcase
    end

endmodule

`default_nettype wire

// ==== exu/exu_pc_ctrl.sv ====
// PC register and start sequence after reset
// Jump / branch redirect, exception detection and trap value

`default_nettype none

module exu_pc_ctrl (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        q_vd,
    input  wire exu_pkg::exu_cmd_t           q_cmd,
    input  wire logic [exu_pkg::xlen-1:0]    sum2_res,
    input  wire logic                        cmp,
    output logic [exu_pkg::xlen-1:0]         curr_pc,
    output logic [exu_pkg::xlen-1:0]         inc_pc,
    output logic                             new_pc_req,
    output logic [exu_pkg::xlen-1:0]         new_pc,
    output logic                             instret,
    output logic                             exc_req,
    output exu_pkg::exc_code_e               exc_code,
    output logic [exu_pkg::xlen-1:0]         trap_val,
    output logic                             init_pc
);
    import exu_pkg::*;

    logic [3:0]      init_pc_v;
    logic            jb_taken;
    logic [xlen-1:0] jb_target;
    logic            jb_misalign;

    //--------------------------------------------------------------------------
    // Start sequence
    //--------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_pc_v <= '0;
        end else if (!(&init_pc_v)) begin
            init_pc_v <= {init_pc_v[2:0], 1'b1};    // Fill with ones, then hold
        end
    end

    assign init_pc = init_pc_v[2] & ~init_pc_v[3];  // Third cycle after release

    //--------------------------------------------------------------------------
    // Exceptions
    //--------------------------------------------------------------------------
    assign jb_taken    = q_vd & (q_cmd.jump_req | (q_cmd.branch_req & cmp));
    assign jb_target   = sum2_res & jump_mask;
    assign jb_misalign = jb_taken & jb_target[1];

    assign exc_req  = q_vd & (q_cmd.exc_req | jb_misalign);
    assign exc_code = q_cmd.exc_req ? q_cmd.exc_code   // Decoder flag wins
                                    : exc_code_instr_misalign;
    assign trap_val = (exc_code == exc_code_instr_misalign) ? jb_target : q_cmd.imm;

    //--------------------------------------------------------------------------
    // PC update
    //--------------------------------------------------------------------------
    assign inc_pc     = curr_pc + xlen'(4);
    assign instret    = q_vd;                       // Every command takes one cycle
    assign new_pc_req = init_pc | exc_req | jb_taken;

    always_comb begin
        if (init_pc) begin
            new_pc = rst_vector;
        end else if (exc_req) begin
            new_pc = trap_vector;
        end else begin
            new_pc = jb_target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= rst_vector;
        end else if (instret | init_pc) begin
            curr_pc <= new_pc_req ? new_pc : inc_pc;
        end
    end

endmodule

`default_nettype wire

// ==== exu/exu_regfile.sv ====
// Integer register file, two asynchronous reads and one write port
// x0 reads as zero

`default_nettype none

module exu_regfile (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic [exu_pkg::rf_addr_width-1:0]    rs1_addr,
    input  wire logic [exu_pkg::rf_addr_width-1:0]    rs2_addr,
    input  wire exu_pkg::rf_wr_t                      wb,
    output logic [exu_pkg::xlen-1:0]                  rs1_data,
    output logic [exu_pkg::xlen-1:0]                  rs2_data
);
    import exu_pkg::*;

    logic [xlen-1:0] regs [rf_depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rf_depth; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.w_req && (wb.rd_addr != '0)) begin
            regs[wb.rd_addr] <= wb.rd_data;         // Writes to x0 dropped
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== source/exu_top.sv ====
// Execute stage top level
// Connects command queue, execute datapath, PC control and register file

`default_nettype none

module exu_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      cmd_req,     // One-cycle command strobe
    input  wire exu_pkg::exu_cmd_t         cmd,
    output exu_pkg::rf_wr_t                wb,
    output logic [exu_pkg::xlen-1:0]       curr_pc,
    output logic                           new_pc_req,
    output logic [exu_pkg::xlen-1:0]       new_pc,
    output logic                           instret,
    output logic                           exc_req,
    output exu_pkg::exc_code_e             exc_code,
    output logic [exu_pkg::xlen-1:0]       trap_val,
    output logic                           init_pc
);
    import exu_pkg::*;

    logic            q_vd;
    exu_cmd_t        q_cmd;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] sum2_res;
    logic            cmp;
    logic [xlen-1:0] inc_pc;

    exu_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .new_pc_req (new_pc_req),
        .q_vd       (q_vd),
        .q_cmd      (q_cmd)
    );

    exu_execute u_execute (
        .q_vd     (q_vd),
        .q_cmd    (q_cmd),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .curr_pc  (curr_pc),
        .inc_pc   (inc_pc),
        .exc_req  (exc_req),
        .sum2_res (sum2_res),
        .cmp      (cmp),
        .wb       (wb)
    );

    exu_pc_ctrl u_pc_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .q_vd       (q_vd),
        .q_cmd      (q_cmd),
        .sum2_res   (sum2_res),
        .cmp        (cmp),
        .curr_pc    (curr_pc),
        .inc_pc     (inc_pc),
        .new_pc_req (new_pc_req),
        .new_pc     (new_pc),
        .instret    (instret),
        .exc_req    (exc_req),
        .exc_code   (exc_code),
        .trap_val   (trap_val),
        .init_pc    (init_pc)
    );

    exu_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (q_cmd.rs1_addr),
        .rs2_addr (q_cmd.rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

`default_nettype wire

// ==== tests/exu_props.sv ====
// Concurrent assertions on the command queue, start sequence and write-back
// Bound into the execute stage top level

`default_nettype none

module exu_props (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic cmd_req,
    input wire logic new_pc_req,
    input wire logic q_vd,
    input wire logic init_pc,
    input wire logic w_req,
    input wire logic exc_req
);

    int fail_count = 0;                               // Read by the testbench at the end

    init_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        init_pc |=> !init_pc)
        else begin
            $error("init_pc stayed high for more than one cycle");
            fail_count++;
        end

    drop_on_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        (new_pc_req && cmd_req) |=> !q_vd)
        else begin
            $error("Command strobed during a redirect was queued");
            fail_count++;
        end

    no_wb_on_trap: assert property (@(posedge clk) disable iff (!rst_n)
        !(w_req && exc_req))
        else begin
            $error("Register write together with an exception");
            fail_count++;
        end

endmodule

bind exu_top exu_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_req    (cmd_req),
    .new_pc_req (new_pc_req),
    .q_vd       (q_vd),
    .init_pc    (init_pc),
    .w_req      (wb.w_req),
    .exc_req    (exc_req)
);

`default_nettype wire

// ==== tests/exu_checker.sv ====
// Reference model of the register file and PC
// Compares every DUT output each cycle and counts redirects and exceptions

`default_nettype none

module exu_checker (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     cmd_req,
    input  wire exu_pkg::exu_cmd_t        cmd,
    input  wire exu_pkg::rf_wr_t          wb,
    input  wire logic [exu_pkg::xlen-1:0] curr_pc,
    input  wire logic                     new_pc_req,
    input  wire logic [exu_pkg::xlen-1:0] new_pc,
    input  wire logic                     instret,
    input  wire logic                     exc_req,
    input  wire exu_pkg::exc_code_e       exc_code,
    input  wire logic [exu_pkg::xlen-1:0] trap_val,
    input  wire logic                     init_pc,
    output int                            err_count,
    output int                            check_count,
    output int                            discards,
    output int                            misaligns,
    output int                            illegals
);
    import exu_pkg::*;

    typedef struct packed {
        logic                     w_req;
        logic [rf_addr_width-1:0] rd;
        logic [xlen-1:0]          data;
        logic                     redirect;
        logic [xlen-1:0]          next_pc;
        logic                     exc;
        exc_code_e                code;
        logic [xlen-1:0]          tval;
    } ref_res_t;

    logic [xlen-1:0] ref_regs [rf_depth];
    logic [xlen-1:0] ref_pc;
    logic            model_vd;
    exu_cmd_t        model_cmd;
    ref_res_t        res;
    logic            exp_init;
    logic            exp_redirect;
    logic            seen_rst = 1'b0;
    int              edges;
    string           cur_test;

    //------------------------------------------------------------------------
    // Reference model of one retiring command
    //------------------------------------------------------------------------
    function automatic ref_res_t predict(input exu_cmd_t c, input logic [xlen-1:0] pc,
                                         input logic [xlen-1:0] r1,
                                         input logic [xlen-1:0] r2);
        ref_res_t        r;
        logic [xlen-1:0] b;
        logic [xlen-1:0] alu;
        logic [xlen-1:0] sum;
        logic [xlen-1:0] target;
        logic            cond;
        logic            taken;
        b    = (c.ialu_op == ialu_op_reg_imm) ? c.imm : r2;
        alu  = '0;
        cond = 1'b0;
        case (c.ialu_cmd)
            ialu_cmd_add:  alu = r1 + b;
            ialu_cmd_sub:  alu = r1 - b;
            ialu_cmd_and:  alu = r1 & b;
            ialu_cmd_or:   alu = r1 | b;
            ialu_cmd_xor:  alu = r1 ^ b;
            ialu_cmd_sll:  alu = r1 << b[4:0];
            ialu_cmd_srl:  alu = r1 >> b[4:0];
            ialu_cmd_sra:  alu = $signed(r1) >>> b[4:0];
            ialu_cmd_slt:  alu = ($signed(r1) < $signed(b)) ? 32'd1 : 32'd0;
            ialu_cmd_sltu: alu = (r1 < b) ? 32'd1 : 32'd0;
            ialu_cmd_eq:   cond = (r1 == b);
            ialu_cmd_ne:   cond = (r1 != b);
            ialu_cmd_lt:   cond = ($signed(r1) < $signed(b));
            ialu_cmd_ge:   cond = ($signed(r1) >= $signed(b));
            ialu_cmd_ltu:  cond = (r1 < b);
            ialu_cmd_geu:  cond = (r1 >= b);
            default:       alu = '0;
        endcase
        sum       = ((c.sum2_op == sum2_op_pc_imm) ? pc : r1) + c.imm;
        target    = {sum[xlen-1:1], 1'b0};        // Bit 0 dropped
        taken     = c.jump_req | (c.branch_req & cond);
        r.exc     = c.exc_req | (taken & target[1]);
        r.code    = c.exc_req ? exc_code_illegal_instr : exc_code_instr_misalign;
        r.tval    = c.exc_req ? c.imm : target;
        r.redirect = r.exc | taken;
        r.next_pc = r.exc ? trap_vector : (taken ? target : pc + 32'd4);
        r.w_req   = (c.rd_wb_sel != rd_wb_none) & ~r.exc;
        r.rd      = c.rd_addr;
        case (c.rd_wb_sel)
            rd_wb_ialu:   r.data = alu;
            rd_wb_sum2:   r.data = sum;
            rd_wb_imm:    r.data = c.imm;
            rd_wb_inc_pc: r.data = pc + 32'd4;
            default:      r.data = '0;
        endcase
        return r;
    endfunction

    task automatic compare(input string name, input logic [xlen-1:0] expected,
                           input logic [xlen-1:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("ERR %s %s: expected %h actual %h at %0t",
                     cur_test, name, expected, actual, $time);
            err_count++;
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        compare(name, 32'(expected), 32'(actual));
    endtask

    //------------------------------------------------------------------------
    // Per-cycle comparison, sampled on the rising edge
    //------------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            cur_test = "reset";
            if (!seen_rst) begin
                err_count   = 0;
                check_count = 0;
                discards    = 0;
                misaligns   = 0;
                illegals    = 0;
            end else begin
                compare_bit("instret", 1'b0, instret);
                compare_bit("wb.w_req", 1'b0, wb.w_req);
                compare_bit("new_pc_req", 1'b0, new_pc_req);
                compare_bit("exc_req", 1'b0, exc_req);
                compare("curr_pc", rst_vector, curr_pc);
            end
            seen_rst  = 1'b1;
            edges     = 0;
            model_vd  = 1'b0;
            model_cmd = '0;
            ref_pc    = rst_vector;
            for (int i = 0; i < rf_depth; i++) begin
                ref_regs[i] = '0;
            end
        end else begin
            cur_test     = model_vd ? model_cmd.ialu_cmd.name() : "idle";
            exp_init     = (edges == 3);              // Third cycle after release
            res          = predict(model_cmd, ref_pc, ref_regs[model_cmd.rs1_addr],
                                   ref_regs[model_cmd.rs2_addr]);
            exp_redirect = exp_init | (model_vd & res.redirect);
            compare_bit("init_pc", exp_init, init_pc);
            compare_bit("instret", model_vd, instret);
            compare_bit("new_pc_req", exp_redirect, new_pc_req);
            compare_bit("exc_req", model_vd & res.exc, exc_req);
            compare_bit("wb.w_req", model_vd & res.w_req, wb.w_req);
            compare("curr_pc", ref_pc, curr_pc);
            if (exp_redirect) begin
                compare("new_pc", exp_init ? rst_vector : res.next_pc, new_pc);
            end
            if (model_vd && res.w_req) begin
                compare("wb.rd_addr", 32'(res.rd), 32'(wb.rd_addr));
                compare("wb.rd_data", res.data, wb.rd_data);
            end
            if (model_vd && res.exc) begin
                compare("exc_code", 32'(res.code), 32'(exc_code));
                compare("trap_val", res.tval, trap_val);
                if (res.code == exc_code_illegal_instr) begin
                    illegals++;
                end else begin
                    misaligns++;
                end
            end
            // Retire into the model
            if (model_vd) begin
                if (res.w_req && (res.rd != '0)) begin
                    ref_regs[res.rd] = res.data;
                end
                ref_pc = res.next_pc;
            end
            if (exp_init) begin
                ref_pc = rst_vector;
            end
            if (cmd_req && exp_redirect) begin
                discards++;
            end
            model_vd = cmd_req & ~exp_redirect;       // Wrong-path strobe lost
            if (cmd_req) begin
                model_cmd = cmd;
            end
            edges++;
        end
    end

endmodule

`default_nettype wire

// ==== tests/exu_tb.sv ====
// Testbench top: clock, reset, random command stimulus and timeout
// Instantiates the execute stage and its checker

`default_nettype none

module exu_tb;
    import exu_pkg::*;

    localparam int n_cmds     = 400;
    localparam int max_cycles = 4 * n_cmds + 50;

    logic            clk;
    logic            rst_n;
    logic            cmd_req;
    exu_cmd_t        cmd;
    rf_wr_t          wb;
    logic [xlen-1:0] curr_pc;
    logic            new_pc_req;
    logic [xlen-1:0] new_pc;
    logic            instret;
    logic            exc_req;
    exc_code_e       exc_code;
    logic [xlen-1:0] trap_val;
    logic            init_pc;

    integer seed;
    int     cycles = 0;
    int     sent;
    int     gaps;
    int     assert_fails;
    int     err_count;
    int     check_count;
    int     discards;
    int     misaligns;
    int     illegals;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    exu_top u_exu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .wb         (wb),
        .curr_pc    (curr_pc),
        .new_pc_req (new_pc_req),
        .new_pc     (new_pc),
        .instret    (instret),
        .exc_req    (exc_req),
        .exc_code   (exc_code),
        .trap_val   (trap_val),
        .init_pc    (init_pc)
    );

    exu_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_req     (cmd_req),
        .cmd         (cmd),
        .wb          (wb),
        .curr_pc     (curr_pc),
        .new_pc_req  (new_pc_req),
        .new_pc      (new_pc),
        .instret     (instret),
        .exc_req     (exc_req),
        .exc_code    (exc_code),
        .trap_val    (trap_val),
        .init_pc     (init_pc),
        .err_count   (err_count),
        .check_count (check_count),
        .discards    (discards),
        .misaligns   (misaligns),
        .illegals    (illegals)
    );

    //------------------------------------------------------------------------
    // Random decoded command
    //------------------------------------------------------------------------
    function automatic exu_cmd_t random_cmd();
        exu_cmd_t    c;
        logic [31:0] r;
        int          kind;
        c          = '0;
        r          = $random(seed);
        c.rs1_addr = {2'b00, r[2:0]};                 // Few registers, more hazards
        c.rs2_addr = {2'b00, r[5:3]};
        c.rd_addr  = {2'b00, r[8:6]};
        c.imm      = $random(seed);
        kind       = {$random(seed)} % 10;
        case (kind)
            0, 1, 2, 3, 4: begin
                c.ialu_op   = (kind < 3) ? ialu_op_reg_reg : ialu_op_reg_imm;
                c.ialu_cmd  = ialu_cmd_e'(5'(1 + {$random(seed)} % 10));
                c.rd_wb_sel = rd_wb_ialu;
            end
            5: begin                                  // LUI or AUIPC
                c.sum2_op   = sum2_op_pc_imm;
                c.rd_wb_sel = r[9] ? rd_wb_imm : rd_wb_sum2;
            end
            6: begin                                  // JAL or JALR
                c.jump_req  = 1'b1;
                c.sum2_op   = sum2_op_e'(r[10]);
                c.rd_wb_sel = rd_wb_inc_pc;
                c.imm       = (c.imm & 32'h0000_07fe) - 32'h0000_0400;
            end
            7, 8: begin
                c.branch_req = 1'b1;
                c.ialu_cmd   = ialu_cmd_e'(5'(11 + {$random(seed)} % 6));
                c.sum2_op    = sum2_op_pc_imm;
                c.imm        = (c.imm & 32'h0000_07fe) - 32'h0000_0400;
            end
            default: begin                            // Illegal, maybe also misaligned
                c.exc_req   = 1'b1;
                c.exc_code  = exc_code_illegal_instr;
                c.jump_req  = r[11];
                c.sum2_op   = sum2_op_pc_imm;
                c.rd_wb_sel = rd_wb_inc_pc;
                c.imm       = (c.imm & 32'h0000_03fc) | 32'h0000_0002;
            end
        endcase
        return c;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic finish_run();
        gaps         = 0;
        assert_fails = u_exu_top.u_props.fail_count;
        if (discards < 2) begin
            $display("Too few commands were discarded during a redirect");
            gaps++;
        end
        if (misaligns == 0 || illegals == 0) begin
            $display("Misaligned target or illegal instruction never exercised");
            gaps++;
        end
        $display("Summary: %0d checks, %0d mismatches, %0d assertion failures, %0d gaps",
                 check_count, err_count, assert_fails, gaps);
        if (err_count + assert_fails + gaps == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        seed    = 93519;
        sent    = 0;
        rst_n   = 1'b0;
        cmd_req = 1'b0;
        cmd     = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        while (!init_pc) begin
            @(negedge clk);
        end
        // First strobe lands in the start cycle and must be dropped
        while (sent < n_cmds) begin
            cmd_req = (sent == 0) || ({$random(seed)} % 5 != 0);
            cmd     = random_cmd();
            if (cmd_req) begin
                sent++;
            end
            @(negedge clk);
        end
        cmd_req = 1'b0;
        repeat (3) @(negedge clk);                    // Last command retires at N+2
        finish_run();
    end

endmodule

`default_nettype wire

// ==== all.f ====
common/exu_pkg.sv
exu/exu_queue.sv
exu/exu_execute.sv
exu/exu_pc_ctrl.sv
exu/exu_regfile.sv
source/exu_top.sv
tests/exu_props.sv
tests/exu_checker.sv
tests/exu_tb.sv

// ==== Makefile ====
TOP := exu_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir -o exu_sim
	./obj_dir/exu_sim +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
